//--- include/permPipe_cfg.svh
`ifndef PERMPIPE_CFG_SVH
`define PERMPIPE_CFG_SVH

// Truth table over four variables
// one bit per input combination
`define TABLE_WIDTH 16

// Variable 0 fixed, variables 1..3 permuted
// 3! orderings per accepted bot
`define NUM_PERMS 6

// Output FIFO holds 2**4 results
`define FIFO_DEPTH_LOG2 4

// Drain stops grabbing at this fill level
// Leaves some slack below the real depth
`define FIFO_ROOM_LIMIT 12

`endif

//--- logic/permPipePkg.sv
`include "permPipe_cfg.svh"

package permPipePkg;

    // Sum of up to NUM_PERMS table values, read unsigned
    // 6 * 65535 needs 19 bits
    localparam int SumWidth = `TABLE_WIDTH + $clog2(`NUM_PERMS);

    // Count runs 0..NUM_PERMS
    localparam int CountWidth = $clog2(`NUM_PERMS + 1);

    // One permuted bot on its way to the accumulator
    typedef struct packed {
        // Permuted truth table
        logic [`TABLE_WIDTH-1:0] bot;
        // Top captured along with the batch
        logic [`TABLE_WIDTH-1:0] top;
        // Sixth permutation of the batch
        logic last;
        logic valid;
    } permBotT;

    // Finished batch result
    typedef struct packed {
        // Sum of the subset permutations
        logic [SumWidth-1:0] sum;
        // How many permutations passed the subset test
        logic [CountWidth-1:0] count;
    } resultT;

endpackage

//--- logic/permutationGenerator.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module permutationGenerator (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`TABLE_WIDTH-1:0]  bot,
    input  logic [`TABLE_WIDTH-1:0]  top,
    input  logic                     writeBot,
    input  logic                     slowDown,
    output logic                     readyForInputBot,
    output permPipePkg::permBotT     permBot
);

    localparam int IdxW = $clog2(`NUM_PERMS);
    localparam logic [IdxW-1:0] LastIdx = IdxW'(`NUM_PERMS - 1);

    // Batch in progress
    logic active;
    logic [IdxW-1:0] idx;
    logic [`TABLE_WIDTH-1:0] storedBot;
    logic [`TABLE_WIDTH-1:0] storedTop;

    // Registered output fields
    logic outValid;
    logic outLast;
    logic [`TABLE_WIDTH-1:0] outBot;
    logic [`TABLE_WIDTH-1:0] outTop;

    logic accept;
    logic advance;

    // Moves the variables of a 4-input truth table
    // k selects the images of variables 1,2,3 in lexicographic order
    function automatic logic [`TABLE_WIDTH-1:0] permuteTable(
        input logic [`TABLE_WIDTH-1:0] srcTable,
        input logic [IdxW-1:0]         k
    );
        logic [5:0] images;
        logic [3:0] dstIdx;
        logic [3:0] srcIdx;
        logic [`TABLE_WIDTH-1:0] permuted;
        // Images packed as {var1, var2, var3}
        case (k)
            3'd1:    images = {2'd1, 2'd3, 2'd2};
            3'd2:    images = {2'd2, 2'd1, 2'd3};
            3'd3:    images = {2'd2, 2'd3, 2'd1};
            3'd4:    images = {2'd3, 2'd1, 2'd2};
            3'd5:    images = {2'd3, 2'd2, 2'd1};
            default: images = {2'd1, 2'd2, 2'd3};
        endcase
        for (int j = 0; j < `TABLE_WIDTH; j++) begin
            dstIdx = 4'(j);
            srcIdx = '0;
            // Variable 0 stays put
            srcIdx[0] = dstIdx[0];
            // Bit m of j lands at position image(m)
            srcIdx[images[5:4]] = dstIdx[1];
            srcIdx[images[3:2]] = dstIdx[2];
            srcIdx[images[1:0]] = dstIdx[3];
            permuted[j] = srcTable[srcIdx];
        end
        return permuted;
    endfunction

    // Ready while no batch is running
    assign readyForInputBot = ~active;
    assign accept = writeBot & readyForInputBot;
    // Hold position while the accumulator has an ungrabbed result
    assign advance = active & ~slowDown;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active   <= 1'b0;
            idx      <= '0;
            outValid <= 1'b0;
            outLast  <= 1'b0;
        end else begin
            outValid <= 1'b0;
            outLast  <= 1'b0;
            if (accept) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (advance) begin
                outValid <= 1'b1;
                outLast  <= (idx == LastIdx);
                if (idx == LastIdx) begin
                    // Sixth one out, ready again next cycle
                    active <= 1'b0;
                    idx    <= '0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // Batch data and output payload
    always_ff @(posedge clk) begin
        if (accept) begin
            storedBot <= bot;
            storedTop <= top;
        end
        if (advance) begin
            outBot <= permuteTable(storedBot, idx);
            outTop <= storedTop;
        end
    end

    assign permBot = '{bot: outBot, top: outTop, last: outLast, valid: outValid};

    // Outside must respect ready
    writeOnlyWhenReady: assert property (
        @(posedge clk) disable iff (!rstN) writeBot |-> readyForInputBot
    ) else $error("writeBot while readyForInputBot low");

endmodule

//--- logic/permutationAccumulator.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module permutationAccumulator (
    input  logic                  clk,
    input  logic                  rstN,
    input  permPipePkg::permBotT  permBot,
    input  logic                  grab,
    output logic                  slowDown,
    output logic                  resultAvailable,
    output permPipePkg::resultT   result
);

    localparam int SumW = permPipePkg::SumWidth;
    localparam int CountW = permPipePkg::CountWidth;

    // Stage 1 registers
    logic s1Valid;
    logic s1Last;
    logic s1Subset;
    logic [`TABLE_WIDTH-1:0] s1Value;

    // Stage 2 running values for the current batch
    logic [SumW-1:0] runSum;
    logic [CountW-1:0] runCount;
    logic [SumW-1:0] sumNext;
    logic [CountW-1:0] countNext;

    // Batch finishing at this edge
    logic finish;

    // Finished batch waiting for the drain
    permPipePkg::resultT heldResult;

    // Stage 1 control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s1Last  <= 1'b0;
        end else begin
            s1Valid <= permBot.valid;
            s1Last  <= permBot.valid & permBot.last;
        end
    end

    // Stage 1 data
    // subset means no bit set where top is clear
    always_ff @(posedge clk) begin
        s1Subset <= ((permBot.bot & ~permBot.top) == '0);
        s1Value  <= permBot.bot;
    end

    // Add only what passed the subset test
    assign sumNext = s1Subset ? runSum + SumW'(s1Value) : runSum;
    assign countNext = s1Subset ? runCount + 1'b1 : runCount;
    assign finish = s1Valid & s1Last;

    // Stage 2 control and running values
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runSum          <= '0;
            runCount        <= '0;
            resultAvailable <= 1'b0;
        end else begin
            if (s1Valid) begin
                if (s1Last) begin
                    // Batch done, start the next one from zero
                    runSum   <= '0;
                    runCount <= '0;
                end else begin
                    runSum   <= sumNext;
                    runCount <= countNext;
                end
            end
            // Grab clears the flag on the following cycle
            if (grab) begin
                resultAvailable <= 1'b0;
            end
            if (finish) begin
                resultAvailable <= 1'b1;
            end
        end
    end

    // Held result payload
    always_ff @(posedge clk) begin
        if (finish) begin
            heldResult <= '{sum: sumNext, count: countNext};
        end
    end

    assign result = heldResult;

    // Pause the generator until the drain takes the result
    assign slowDown = resultAvailable;

    // The pause must keep the next batch from finishing over an ungrabbed result
    noOverwrite: assert property (
        @(posedge clk) disable iff (!rstN) (finish && resultAvailable) |-> grab
    ) else $error("finished batch overwrote an ungrabbed result");

    // Drain only grabs a result that is there
    grabNeedsResult: assert property (
        @(posedge clk) disable iff (!rstN) grab |-> resultAvailable
    ) else $error("grab without resultAvailable");

endmodule

//--- logic/resultDrain.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module resultDrain (
    input  logic                 clk,
    input  logic                 rstN,
    input  permPipePkg::resultT  result,
    input  logic                 resultAvailable,
    input  logic                 grabResults,
    output logic                 grab,
    output logic                 resultsAvailable,
    output permPipePkg::resultT  pcoeff
);

    localparam int PtrW = `FIFO_DEPTH_LOG2;
    localparam int OccW = `FIFO_DEPTH_LOG2 + 1;
    localparam int Depth = 1 << `FIFO_DEPTH_LOG2;
    localparam logic [OccW-1:0] RoomLimit = OccW'(`FIFO_ROOM_LIMIT);
    localparam logic [OccW-1:0] DepthOcc = OccW'(Depth);

    // Circular buffer
    permPipePkg::resultT mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    // Entries stored from 0 to Depth
    logic [OccW-1:0] occupancy;

    logic doWrite;
    logic doRead;
    logic haveRoom;

    assign haveRoom = (occupancy < RoomLimit);

    // Grab decision
    // One cycle pulse
    // Accumulator drops its flag right after
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            grab <= 1'b0;
        end else begin
            grab <= resultAvailable & ~grab & haveRoom;
        end
    end

    // Result is written in the same cycle grab is high
    assign doWrite = grab;
    // Reads on an empty FIFO are dropped
    assign doRead = grabResults & resultsAvailable;

    // Pointers and fill counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            occupancy <= occupancy + OccW'(doWrite) - OccW'(doRead);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= result;
        end
    end

    // Not-empty flag follows the counter one cycle after a write
    assign resultsAvailable = (occupancy != '0);

    // Head entry shown directly
    assign pcoeff = mem[rdPtr];

    // Room limit should keep writes off a full FIFO
    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (!rstN) doWrite |-> (occupancy < DepthOcc)
    ) else $error("output FIFO written while full");

    // Counter never past the depth
    occupancyInRange: assert property (
        @(posedge clk) disable iff (!rstN) occupancy <= DepthOcc
    ) else $error("output FIFO occupancy out of range");

endmodule

//--- logic/fullPermutationPipeline.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module fullPermutationPipeline (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`TABLE_WIDTH-1:0]  bot,
    input  logic [`TABLE_WIDTH-1:0]  top,
    input  logic                     writeBot,
    output logic                     readyForInputBot,
    input  logic                     grabResults,
    output logic                     resultsAvailable,
    output permPipePkg::resultT      pcoeff
);

    // Generator to accumulator
    permPipePkg::permBotT permBot;
    logic slowDown;

    // Accumulator to drain
    permPipePkg::resultT result;
    logic resultAvailable;
    logic grab;

    // Six permutations per accepted bot
    permutationGenerator permutationGenerator_inst (
        .clk              (clk),
        .rstN             (rstN),
        .bot              (bot),
        .top              (top),
        .writeBot         (writeBot),
        .slowDown         (slowDown),
        .readyForInputBot (readyForInputBot),
        .permBot          (permBot)
    );

    // Subset test and sum per batch
    permutationAccumulator permutationAccumulator_inst (
        .clk             (clk),
        .rstN            (rstN),
        .permBot         (permBot),
        .grab            (grab),
        .slowDown        (slowDown),
        .resultAvailable (resultAvailable),
        .result          (result)
    );

    // Output FIFO and grab logic
    resultDrain resultDrain_inst (
        .clk              (clk),
        .rstN             (rstN),
        .result           (result),
        .resultAvailable  (resultAvailable),
        .grabResults      (grabResults),
        .grab             (grab),
        .resultsAvailable (resultsAvailable),
        .pcoeff           (pcoeff)
    );

endmodule

//--- testbench/resultChecker.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module resultChecker (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`TABLE_WIDTH-1:0]  bot,
    input  logic [`TABLE_WIDTH-1:0]  top,
    input  logic                     writeBot,
    input  logic                     readyForInputBot,
    input  logic                     grabResults,
    input  logic                     resultsAvailable,
    input  permPipePkg::resultT      pcoeff,
    output int                       errorCount,
    output int                       pendingCount,
    output int                       checkedCount
);

    localparam int SumW = permPipePkg::SumWidth;
    localparam int CountW = permPipePkg::CountWidth;

    // Expected results in acceptance order
    permPipePkg::resultT expectedQ[$];
    permPipePkg::resultT head;
    int errors = 0;
    int checked = 0;
    int pending = 0;

    // Reference permutation, straight from the variable mapping
    // Nibbles of code give the images of variables 0..3, left to right
    function automatic logic [15:0] permuteModel(input logic [15:0] src, input int k);
        logic [15:0] code;
        logic [15:0] permuted;
        int srcIndex;
        int p;
        case (k)
            1:       code = 16'h0132;
            2:       code = 16'h0213;
            3:       code = 16'h0231;
            4:       code = 16'h0312;
            5:       code = 16'h0321;
            default: code = 16'h0123;
        endcase
        for (int j = 0; j < 16; j++) begin
            srcIndex = 0;
            // Bit m of j moves to bit image(m) of the source index
            for (int m = 0; m < 4; m++) begin
                p = int'(code[(3 - m) * 4 +: 4]);
                if (((j >> m) & 1) == 1) begin
                    srcIndex = srcIndex | (1 << p);
                end
            end
            permuted[j] = src[srcIndex];
        end
        return permuted;
    endfunction

    // Sum and count over the subset permutations of one batch
    function automatic permPipePkg::resultT expectedResult(
        input logic [15:0] b,
        input logic [15:0] t
    );
        permPipePkg::resultT r;
        logic [15:0] perm;
        int total;
        int hits;
        total = 0;
        hits = 0;
        for (int k = 0; k < `NUM_PERMS; k++) begin
            perm = permuteModel(b, k);
            // Nothing set where top is clear
            if ((perm & ~t) == 16'h0000) begin
                total = total + int'(perm);
                hits = hits + 1;
            end
        end
        r.sum = SumW'(total);
        r.count = CountW'(hits);
        return r;
    endfunction

    always @(posedge clk) begin
        if (rstN) begin
            // Accepted bot, queue its expected result
            if (writeBot && readyForInputBot) begin
                expectedQ.push_back(expectedResult(bot, top));
            end
            // Head pops at this edge
            if (grabResults && resultsAvailable) begin
                if (expectedQ.size() == 0) begin
                    $display("Result read at %0t ns with no result expected", $time);
                    errors++;
                end else begin
                    head = expectedQ.pop_front();
                    checked++;
                    if (pcoeff.sum !== head.sum) begin
                        $display("Fail at %0t ns: pcoeff.sum expected %0d got %0d",
                                 $time, head.sum, pcoeff.sum);
                        errors++;
                    end
                    if (pcoeff.count !== head.count) begin
                        $display("Fail at %0t ns: pcoeff.count expected %0d got %0d",
                                 $time, head.count, pcoeff.count);
                        errors++;
                    end
                end
            end
            pending = expectedQ.size();
        end
    end

    assign errorCount = errors;
    assign pendingCount = pending;
    assign checkedCount = checked;

endmodule

//--- testbench/fullPermutationPipelineTb.sv
`timescale 1ns/1ps

`include "permPipe_cfg.svh"

module fullPermutationPipelineTb;

    localparam int MaxBatches = 200;
    // 40 cycles per batch worst case, plus reset and drain slack
    localparam int TimeoutCycles = MaxBatches * 40 + 500;

    logic clk;
    logic rstN;
    logic [`TABLE_WIDTH-1:0] bot;
    logic [`TABLE_WIDTH-1:0] top;
    logic writeBot;
    logic readyForInputBot;
    logic grabResults;
    logic resultsAvailable;
    permPipePkg::resultT pcoeff;

    logic [15:0] lfsrState;
    int tbErrors;
    int checkerErrors;
    int pending;
    int checkedCount;
    int cycleCount;

    fullPermutationPipeline fullPermutationPipeline_inst (
        .clk              (clk),
        .rstN             (rstN),
        .bot              (bot),
        .top              (top),
        .writeBot         (writeBot),
        .readyForInputBot (readyForInputBot),
        .grabResults      (grabResults),
        .resultsAvailable (resultsAvailable),
        .pcoeff           (pcoeff)
    );

    // Reference model and compare
    resultChecker resultChecker_inst (
        .clk              (clk),
        .rstN             (rstN),
        .bot              (bot),
        .top              (top),
        .writeBot         (writeBot),
        .readyForInputBot (readyForInputBot),
        .grabResults      (grabResults),
        .resultsAvailable (resultsAvailable),
        .pcoeff           (pcoeff),
        .errorCount       (checkerErrors),
        .pendingCount     (pending),
        .checkedCount     (checkedCount)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            tbErrors++;
        end
    endtask

    // Mode 0 keeps top all ones
    // Mode 1 mixes zero bots, subsets of top, all-ones tops and random pairs
    task automatic drawOperands(input int mode);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] pick;
        takeBits(16, a);
        takeBits(16, b);
        takeBits(2, pick);
        if (mode == 0) begin
            bot = a;
            top = 16'hFFFF;
        end else begin
            case (pick[1:0])
                2'd0: begin
                    bot = '0;
                    top = b;
                end
                2'd1: begin
                    bot = a & b;
                    top = b;
                end
                2'd2: begin
                    bot = a;
                    top = 16'hFFFF;
                end
                default: begin
                    bot = a;
                    top = b;
                end
            endcase
        end
    endtask

    // Writes n bots, reads the FIFO at random
    task automatic runBatches(input int n, input int mode);
        int accepted;
        logic [15:0] coin;
        accepted = 0;
        while (accepted < n) begin
            @(negedge clk);
            takeBits(2, coin);
            writeBot = 1'b0;
            // Ready is stable until the next rising edge
            if (readyForInputBot && coin[1:0] != 2'd0) begin
                drawOperands(mode);
                writeBot = 1'b1;
                accepted++;
            end
            takeBits(1, coin);
            grabResults = coin[0];
        end
        @(negedge clk);
        writeBot = 1'b0;
    endtask

    // No reads, so the FIFO fills and back-pressure reaches the input
    task automatic stallOutput(input int cycles, input int quietWindow);
        int lastWrite;
        logic [15:0] coin;
        lastWrite = 0;
        grabResults = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            takeBits(1, coin);
            writeBot = 1'b0;
            if (readyForInputBot && coin[0]) begin
                drawOperands(1);
                writeBot = 1'b1;
                lastWrite = c;
            end
        end
        @(negedge clk);
        writeBot = 1'b0;
        checkLevel("readyForInputBot", 1'b0, readyForInputBot);
        checkLevel("resultsAvailable", 1'b1, resultsAvailable);
        if (cycles - lastWrite < quietWindow) begin
            $display("Writes were still accepted late in the stall, last at cycle %0d", lastWrite);
            tbErrors++;
        end
    endtask

    // Read until every queued result is out
    task automatic drainAll();
        grabResults = 1'b1;
        while (pending != 0) begin
            @(negedge clk);
        end
        grabResults = 1'b0;
        repeat (5) @(negedge clk);
        checkLevel("resultsAvailable", 1'b0, resultsAvailable);
    endtask

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        bot = '0;
        top = '0;
        writeBot = 1'b0;
        grabResults = 1'b0;
        lfsrState = 16'd73;
        tbErrors = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        // Idle state before any write
        checkLevel("readyForInputBot", 1'b1, readyForInputBot);
        checkLevel("resultsAvailable", 1'b0, resultsAvailable);
        runBatches(40, 0);
        runBatches(40, 1);
        stallOutput(400, 150);
        runBatches(60, 1);
        drainAll();
        $display("Errors: %0d checker, %0d testbench; %0d results checked",
                 checkerErrors, tbErrors, checkedCount);
        if (checkerErrors == 0 && tbErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
logic/permPipePkg.sv
logic/permutationGenerator.sv
logic/permutationAccumulator.sv
logic/resultDrain.sv
logic/fullPermutationPipeline.sv
testbench/resultChecker.sv
testbench/fullPermutationPipelineTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench into sim.log, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module fullPermutationPipelineTb -Mdir obj_dir \
    && { ./obj_dir/VfullPermutationPipelineTb > sim.log 2>&1 || true; }
cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
